/* verilog/dbg_mem_pkg.sv */
// --------------------
// debug memory address map, command types and RISC-V encoders
// --------------------
package dbg_mem_pkg;

    // --------------------
    // sizes and address map
    // --------------------
    localparam int dbg_addr_bits  = 12;
    localparam int bus_width      = 64;
    localparam int data_count     = 2;
    localparam int prog_buf_size  = 8;
    localparam int abs_prog_words = 5;

    localparam logic [11:0] data_addr      = 12'h380;
    localparam logic [11:0] data_end       = data_addr + 12'(4 * data_count - 1);
    localparam logic [11:0] prog_buf_base  = data_addr - 12'(4 * prog_buf_size);
    localparam logic [11:0] prog_buf_end   = data_addr - 12'd1;
    localparam logic [11:0] abs_cmd_base   = prog_buf_base - 12'(8 * abs_prog_words);
    localparam logic [11:0] abs_cmd_end    = prog_buf_base - 12'd1;
    localparam logic [11:0] where_to_addr  = 12'h300;
    localparam logic [11:0] flags_base     = 12'h400;
    localparam logic [11:0] flags_end      = 12'h407;
    localparam logic [11:0] halted_addr    = 12'h100;
    localparam logic [11:0] going_addr     = 12'h104;
    localparam logic [11:0] resuming_addr  = 12'h108;
    localparam logic [11:0] exception_addr = 12'h10C;
    localparam logic [11:0] resume_addr    = 12'h804;

    localparam logic [11:0] csr_dscratch0 = 12'h7B2;
    localparam logic [11:0] csr_dscratch1 = 12'h7B3;

    // scratch registers used by the abstract program
    localparam logic [4:0] reg_s0 = 5'd8;
    localparam logic [4:0] reg_a0 = 5'd10;

    // hart control FSM encoding
    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_go     = 2'd1;
    localparam logic [1:0] st_resume = 2'd2;
    localparam logic [1:0] st_exec   = 2'd3;

    // --------------------
    // abstract command types
    // --------------------
    typedef enum logic [7:0] {
        access_register = 8'h00,
        quick_access    = 8'h01,
        access_memory   = 8'h02
    } cmd_type_e;

    typedef enum logic [2:0] {
        cmderr_none          = 3'd0,
        cmderr_not_supported = 3'd2,
        cmderr_exception     = 3'd3,
        cmderr_halt_resume   = 3'd4
    } cmderr_e;

    // access register control field in msb first order
    typedef struct packed {
        logic        reserved;
        logic [2:0]  aarsize;
        logic        postincrement;
        logic        postexec;
        logic        transfer;
        logic        write;
        logic [15:0] regno;
    } ac_ar_t;

    typedef struct packed {
        cmd_type_e   cmdtype;
        logic [23:0] control;
    } cmd_raw_t;

    typedef struct packed {
        cmd_type_e cmdtype;
        ac_ar_t    ar;
    } cmd_acc_t;

    // same command word as a generic or access register view
    typedef union packed {
        cmd_raw_t raw;
        cmd_acc_t acc;
    } command_u;

    // --------------------
    // instruction encoders
    // --------------------
    function automatic logic [31:0] jal(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
    endfunction

    function automatic logic [31:0] auipc(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, 7'h17};
    endfunction

    function automatic logic [31:0] srli(logic [4:0] rd, logic [4:0] rs1, logic [5:0] shamt);
        return {6'b0, shamt, rs1, 3'h5, rd, 7'h13};
    endfunction

    function automatic logic [31:0] slli(logic [4:0] rd, logic [4:0] rs1, logic [5:0] shamt);
        return {6'b0, shamt, rs1, 3'h1, rd, 7'h13};
    endfunction

    function automatic logic [31:0] csrw(logic [11:0] csr, logic [4:0] rs1);
        return {csr, rs1, 3'h1, 5'h0, 7'h73};
    endfunction

    function automatic logic [31:0] csrr(logic [11:0] csr, logic [4:0] rd);
        return {csr, 5'h0, 3'h2, rd, 7'h73};
    endfunction

    // size is the funct3 width code matching aarsize
    function automatic logic [31:0] load(logic [2:0] size, logic [4:0] rd, logic [4:0] base,
                                         logic [11:0] offset);
        return {offset, base, size, rd, 7'h03};
    endfunction

    function automatic logic [31:0] store(logic [2:0] size, logic [4:0] src, logic [4:0] base,
                                          logic [11:0] offset);
        return {offset[11:5], src, base, size, offset[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] ebreak();
        return 32'h0010_0073;
    endfunction

    function automatic logic [31:0] nop();
        return 32'h0000_0013;
    endfunction

    function automatic logic [31:0] illegal();
        return 32'h0000_0000;
    endfunction

endpackage

/* verilog/dbg_hart_ctrl.sv */
// --------------------
// command/resume control FSM and hart status flags
// --------------------
`timescale 1ns/100ps

module dbg_hart_ctrl import dbg_mem_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    cmd_valid_i,
    input  logic    haltreq_i,
    input  logic    resumereq_i,
    input  logic    unsupported_i,
    input  logic    halted_wr_i,
    input  logic    going_wr_i,
    input  logic    resuming_wr_i,
    input  logic    exception_wr_i,
    output logic    cmdbusy_o,
    output logic    go_o,
    output logic    resume_o,
    output logic    halted_o,
    output logic    resuming_o,
    output logic    cmderror_valid_o,
    output cmderr_e cmderror_o
);

    logic [1:0] state_d, state_q;
    logic       halted_d, halted_q;
    logic       resuming_d, resuming_q;

    assign halted_o   = halted_q;
    assign resuming_o = resuming_q;

    always_comb begin
        state_d          = state_q;
        cmdbusy_o        = 1'b1;
        go_o             = 1'b0;
        resume_o         = 1'b0;
        cmderror_valid_o = 1'b0;
        cmderror_o       = cmderr_none;

        case (state_q)
            st_idle: begin
                cmdbusy_o = 1'b0;
                if (cmd_valid_i) begin
                    cmderror_valid_o = unsupported_i || !halted_q;
                    if (unsupported_i) begin
                        cmderror_o = cmderr_not_supported;
                    end else if (!halted_q) begin
                        // commands only run on a halted hart
                        cmderror_o = cmderr_halt_resume;
                    end else begin
                        state_d = st_go;
                    end
                end
                // resume ignored until the previous ack was cleared
                if (resumereq_i && !resuming_q && !haltreq_i && halted_q) begin
                    state_d = st_resume;
                end
            end
            st_go: begin
                go_o = 1'b1;
                if (going_wr_i) begin
                    state_d = st_exec;
                end
            end
            // hart halts again once the program hits ebreak
            st_exec: begin
                if (halted_wr_i) begin
                    state_d = st_idle;
                end
            end
            st_resume: begin
                resume_o = 1'b1;
                if (resuming_q) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase

        if (exception_wr_i) begin
            cmderror_valid_o = 1'b1;
            cmderror_o       = cmderr_exception;
        end
    end

    // --------------------
    // status flags
    // --------------------
    always_comb begin
        halted_d   = (halted_q || halted_wr_i) && !resuming_wr_i;
        resuming_d = (resuming_q && resumereq_i) || resuming_wr_i;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= st_idle;
            halted_q   <= 1'b0;
            resuming_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            halted_q   <= halted_d;
            resuming_q <= resuming_d;
        end
    end

endmodule

/* verilog/dbg_abstract_prog.sv */
// --------------------
// abstract command program built from the command word
// --------------------
`timescale 1ns/100ps

module dbg_abstract_prog import dbg_mem_pkg::*; (
    input  command_u                          cmd_i,
    output logic [abs_prog_words-1:0][63:0]   prog_o,
    output logic                              unsupported_o
);

    ac_ar_t      ar;
    logic        is_a0;
    logic [11:0] csr_sel;

    assign ar = cmd_i.acc.ar;

    // a0 holds the DM base so its value is parked in dscratch1
    assign is_a0   = ar.regno[12] && (ar.regno[4:0] == reg_a0);
    assign csr_sel = is_a0 ? csr_dscratch1 : ar.regno[11:0];

    always_comb begin
        unsupported_o = 1'b0;

        // --------------------
        // default program
        // --------------------
        // auipc/srli/slli leave the 4k aligned DM base in a0
        prog_o[0] = {auipc(reg_a0, 20'h0), illegal()};
        prog_o[1] = {slli(reg_a0, reg_a0, 6'd12), srli(reg_a0, reg_a0, 6'd12)};
        prog_o[2] = {nop(), nop()};
        prog_o[3] = {nop(), nop()};
        prog_o[4] = {ebreak(), csrr(csr_dscratch1, reg_a0)};

        case (cmd_i.raw.cmdtype)
            access_register: begin
                if (ar.transfer && (ar.aarsize < 3'd4)) begin
                    // save a0 before it gets the base address
                    prog_o[0][31:0] = csrw(csr_dscratch1, reg_a0);

                    if ((ar.regno[15:14] != 2'b00) || (ar.regno[12] && ar.regno[5])) begin
                        // reserved range and FPRs trap right away
                        prog_o[0][31:0] = illegal();
                    end else if (ar.regno[12] && !is_a0) begin
                        // plain GPR goes straight to or from the data registers
                        if (ar.write) begin
                            prog_o[2][31:0] = load(ar.aarsize, ar.regno[4:0], reg_a0, data_addr);
                        end else begin
                            prog_o[2][31:0] = store(ar.aarsize, ar.regno[4:0], reg_a0, data_addr);
                        end
                    end else begin
                        // CSR or a0 moved through s0
                        prog_o[2][31:0]  = csrw(csr_dscratch0, reg_s0);
                        prog_o[3][63:32] = csrr(csr_dscratch0, reg_s0);
                        if (ar.write) begin
                            prog_o[2][63:32] = load(ar.aarsize, reg_s0, reg_a0, data_addr);
                            prog_o[3][31:0]  = csrw(csr_sel, reg_s0);
                        end else begin
                            prog_o[2][63:32] = csrr(csr_sel, reg_s0);
                            prog_o[3][31:0]  = store(ar.aarsize, reg_s0, reg_a0, data_addr);
                        end
                    end
                end

                // fall through into the program buffer
                if (ar.postexec) begin
                    prog_o[4][63:32] = nop();
                end
            end
            // quick access and memory access
            default: unsupported_o = 1'b1;
        endcase
    end

endmodule

/* verilog/dbg_bus_mem.sv */
// --------------------
// hart bus decode with flag writes, data registers and read mux
// --------------------
`timescale 1ns/100ps

module dbg_bus_mem import dbg_mem_pkg::*; (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                req_i,
    input  logic                                we_i,
    input  logic [bus_width-1:0]                addr_i,
    input  logic [bus_width-1:0]                wdata_i,
    input  logic [bus_width/8-1:0]              be_i,
    input  logic [data_count-1:0][31:0]         data_i,
    input  logic [prog_buf_size-1:0][31:0]      progbuf_i,
    input  logic [abs_prog_words-1:0][63:0]     prog_i,
    input  command_u                            cmd_i,
    input  logic                                cmdbusy_i,
    input  logic                                go_i,
    input  logic                                resume_i,
    input  logic                                resumereq_i,
    output logic [bus_width-1:0]                rdata_o,
    output logic [data_count-1:0][31:0]         data_o,
    output logic                                data_valid_o,
    output logic                                halted_wr_o,
    output logic                                going_wr_o,
    output logic                                resuming_wr_o,
    output logic                                exception_wr_o
);

    logic [dbg_addr_bits-1:0]               addr;
    logic [prog_buf_size/2-1:0][63:0]       progbuf;
    logic [dbg_addr_bits-4:0]               pb_idx;
    logic [dbg_addr_bits-4:0]               ac_idx;
    logic [63:0]                            data_bits;
    logic [bus_width-1:0]                   rdata_d;

    assign addr    = addr_i[dbg_addr_bits-1:0];
    assign progbuf = progbuf_i;

    // doubleword index inside each window
    assign pb_idx = addr[dbg_addr_bits-1:3] - prog_buf_base[dbg_addr_bits-1:3];
    assign ac_idx = addr[dbg_addr_bits-1:3] - abs_cmd_base[dbg_addr_bits-1:3];

    // --------------------
    // writes
    // --------------------
    always_comb begin
        halted_wr_o    = 1'b0;
        going_wr_o     = 1'b0;
        resuming_wr_o  = 1'b0;
        exception_wr_o = 1'b0;
        data_valid_o   = 1'b0;
        data_bits      = data_i;
        if (req_i && we_i) begin
            case (addr) inside
                halted_addr:    halted_wr_o    = 1'b1;
                going_addr:     going_wr_o     = 1'b1;
                resuming_addr:  resuming_wr_o  = 1'b1;
                exception_addr: exception_wr_o = 1'b1;
                [data_addr:data_end]: begin
                    data_valid_o = 1'b1;
                    for (int i = 0; i < bus_width / 8; i++) begin
                        if (be_i[i]) begin
                            data_bits[i*8 +: 8] = wdata_i[i*8 +: 8];
                        end
                    end
                end
                default: ;
            endcase
        end
        data_o = data_bits;
    end

    // --------------------
    // reads
    // --------------------
    always_comb begin
        rdata_d = '0;
        case (addr) inside
            where_to_addr: begin
                // jump target is relative to the whereto slot
                if (cmdbusy_i) begin
                    if (cmd_i.acc.ar.transfer) begin
                        rdata_d = {32'b0, jal(5'd0, {9'b0, abs_cmd_base - where_to_addr})};
                    end else begin
                        rdata_d = {32'b0, jal(5'd0, {9'b0, prog_buf_base - where_to_addr})};
                    end
                end else if (resumereq_i) begin
                    rdata_d = {32'b0, jal(5'd0, {9'b0, resume_addr - where_to_addr})};
                end
            end
            [flags_base:flags_end]:       rdata_d = {62'b0, resume_i, go_i};
            [prog_buf_base:prog_buf_end]: rdata_d = progbuf[pb_idx[1:0]];
            [abs_cmd_base:abs_cmd_end]:   rdata_d = prog_i[ac_idx[2:0]];
            [data_addr:data_end]:         rdata_d = data_i;
            default: ;
        endcase
    end

    // read data holds until the next read
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_o <= '0;
        end else if (req_i && !we_i) begin
            rdata_o <= rdata_d;
        end
    end

endmodule

/* verilog/dbg_mem_top.sv */
// --------------------
// debug memory front end top level
// --------------------
`timescale 1ns/100ps

module dbg_mem_top import dbg_mem_pkg::*; (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            haltreq_i,
    input  logic                            resumereq_i,
    input  logic                            cmd_valid_i,
    input  command_u                        cmd_i,
    input  logic [prog_buf_size-1:0][31:0]  progbuf_i,
    input  logic [data_count-1:0][31:0]     data_i,
    input  logic                            req_i,
    input  logic                            we_i,
    input  logic [bus_width-1:0]            addr_i,
    input  logic [bus_width-1:0]            wdata_i,
    input  logic [bus_width/8-1:0]          be_i,
    output logic [bus_width-1:0]            rdata_o,
    output logic [data_count-1:0][31:0]     data_o,
    output logic                            data_valid_o,
    output logic                            cmderror_valid_o,
    output cmderr_e                         cmderror_o,
    output logic                            cmdbusy_o,
    output logic                            halted_o,
    output logic                            resuming_o
);

    logic                               halted_wr, going_wr, resuming_wr, exception_wr;
    logic                               go, resume, unsupported;
    logic [abs_prog_words-1:0][63:0]    prog;

    dbg_hart_ctrl i_hart_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .cmd_valid_i      (cmd_valid_i),
        .haltreq_i        (haltreq_i),
        .resumereq_i      (resumereq_i),
        .unsupported_i    (unsupported),
        .halted_wr_i      (halted_wr),
        .going_wr_i       (going_wr),
        .resuming_wr_i    (resuming_wr),
        .exception_wr_i   (exception_wr),
        .cmdbusy_o        (cmdbusy_o),
        .go_o             (go),
        .resume_o         (resume),
        .halted_o         (halted_o),
        .resuming_o       (resuming_o),
        .cmderror_valid_o (cmderror_valid_o),
        .cmderror_o       (cmderror_o)
    );

    dbg_abstract_prog i_abstract_prog (
        .cmd_i         (cmd_i),
        .prog_o        (prog),
        .unsupported_o (unsupported)
    );

    dbg_bus_mem i_bus_mem (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .req_i          (req_i),
        .we_i           (we_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .be_i           (be_i),
        .data_i         (data_i),
        .progbuf_i      (progbuf_i),
        .prog_i         (prog),
        .cmd_i          (cmd_i),
        .cmdbusy_i      (cmdbusy_o),
        .go_i           (go),
        .resume_i       (resume),
        .resumereq_i    (resumereq_i),
        .rdata_o        (rdata_o),
        .data_o         (data_o),
        .data_valid_o   (data_valid_o),
        .halted_wr_o    (halted_wr),
        .going_wr_o     (going_wr),
        .resuming_wr_o  (resuming_wr),
        .exception_wr_o (exception_wr)
    );

endmodule

/* test/dbg_mem_properties.sv */
// --------------------
// concurrent checks on the debug memory top level ports
// --------------------
`timescale 1ns/100ps

module dbg_mem_properties import dbg_mem_pkg::*; (
    input logic    clk_i,
    input logic    rst_ni,
    input logic    cmderror_valid_i,
    input cmderr_e cmderror_i,
    input logic    cmdbusy_i,
    input logic    halted_i,
    input logic    resuming_i
);

    // sticky flag set by any failing check below
    logic assert_failed = 1'b0;

    err_has_code: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cmderror_valid_i |-> (cmderror_i != cmderr_none))
    else begin
        assert_failed = 1'b1;
        $error("command error flagged with code none");
    end

    no_busy_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !cmdbusy_i)
    else begin
        assert_failed = 1'b1;
        $error("cmdbusy high while reset is asserted");
    end

    // resuming ack only ever follows a halted hart
    resume_after_halt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(resuming_i) |-> $past(halted_i))
    else begin
        assert_failed = 1'b1;
        $error("resuming rose without a preceding halt");
    end

endmodule

/* test/tb_dbg_mem.sv */
// --------------------
// table driven testbench for the debug memory front end
// --------------------
`timescale 1ns/100ps

module tb_dbg_mem;
    import dbg_mem_pkg::*;

    typedef enum {op_cmd, op_write, op_read, op_wait, op_resreq} op_e;

    // wdata carries the command word for op_cmd and the level for op_resreq
    typedef struct {
        op_e         op;
        logic [11:0] addr;
        logic [63:0] wdata;
        logic [7:0]  be;
        logic [63:0] exp;
        cmderr_e     err;
        logic [2:0]  st;
    } row_t;

    logic                           clk_i;
    logic                           rst_ni;
    logic                           haltreq_i, resumereq_i, cmd_valid_i;
    command_u                       cmd_i;
    logic [prog_buf_size-1:0][31:0] progbuf_i;
    logic [data_count-1:0][31:0]    data_i;
    logic                           req_i, we_i;
    logic [bus_width-1:0]           addr_i, wdata_i;
    logic [bus_width/8-1:0]         be_i;
    logic [bus_width-1:0]           rdata_o;
    logic [data_count-1:0][31:0]    data_o;
    logic                           data_valid_o, cmderror_valid_o;
    cmderr_e                        cmderror_o;
    logic                           cmdbusy_o, halted_o, resuming_o;

    row_t   stim[$];
    integer seed;
    int     busy_limit = 50;

    dbg_mem_top UUT (.*);

    bind dbg_mem_top dbg_mem_properties i_props (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .cmderror_valid_i (cmderror_valid_o),
        .cmderror_i       (cmderror_o),
        .cmdbusy_i        (cmdbusy_o),
        .halted_i         (halted_o),
        .resuming_i       (resuming_o)
    );

    always #50 clk_i = ~clk_i;

    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    always @(posedge clk_i) begin
        if (UUT.i_props.assert_failed) begin
            $display("a bound assertion failed during the run");
            fail_run();
        end
    end

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_rdata(logic [63:0] got, logic [63:0] exp, string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is 0x%016h, expected 0x%016h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_err(logic valid, cmderr_e got, cmderr_e exp);
        if ((exp == cmderr_none) ? (valid !== 1'b0) : (valid !== 1'b1 || got !== exp)) begin
            $display("Error at %0t ns: cmderror valid %0b code %0d, expected code %0d",
                     $time, valid, got, exp);
            fail_run();
        end
    endtask

    task automatic check_status(logic [2:0] got, logic [2:0] exp, string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            fail_run();
        end
    endtask

    // --------------------
    // expected values
    // --------------------
    function automatic logic [63:0] merge_bytes(logic [63:0] old, logic [63:0] wr, logic [7:0] be);
        logic [63:0] res;
        res = old;
        for (int i = 0; i < 8; i++) begin
            if (be[i]) res[i*8 +: 8] = wr[i*8 +: 8];
        end
        return res;
    endfunction

    function automatic logic [63:0] jump_from_whereto(logic [11:0] target);
        return {32'b0, jal(5'd0, {9'b0, target - where_to_addr})};
    endfunction

    function automatic logic [63:0] exp_prog(command_u c, int k);
        logic [63:0] w [5];
        ac_ar_t      ar;
        logic        gpr, is_a0;
        logic [11:0] csr;
        ar    = c.acc.ar;
        gpr   = ar.regno[12];
        is_a0 = gpr && (ar.regno[4:0] == reg_a0);
        csr   = is_a0 ? csr_dscratch1 : ar.regno[11:0];
        w[0] = {auipc(reg_a0, 20'h0), illegal()};
        w[1] = {slli(reg_a0, reg_a0, 6'd12), srli(reg_a0, reg_a0, 6'd12)};
        w[2] = {nop(), nop()};
        w[3] = {nop(), nop()};
        w[4] = {ar.postexec ? nop() : ebreak(), csrr(csr_dscratch1, reg_a0)};
        if (ar.transfer) begin
            w[0][31:0] = csrw(csr_dscratch1, reg_a0);
            if (gpr && !is_a0) begin
                w[2][31:0] = ar.write ? load(ar.aarsize, ar.regno[4:0], reg_a0, data_addr)
                                      : store(ar.aarsize, ar.regno[4:0], reg_a0, data_addr);
            end else begin
                // csr or a0 goes through s0
                w[2] = {ar.write ? load(ar.aarsize, reg_s0, reg_a0, data_addr)
                                 : csrr(csr, reg_s0), csrw(csr_dscratch0, reg_s0)};
                w[3] = {csrr(csr_dscratch0, reg_s0), ar.write ? csrw(csr, reg_s0)
                                 : store(ar.aarsize, reg_s0, reg_a0, data_addr)};
            end
        end
        return w[k];
    endfunction

    function automatic command_u make_cmd(logic transfer, logic write, logic postexec,
                                          logic [2:0] size, logic [15:0] regno);
        command_u c;
        c = '0;
        c.acc.cmdtype        = access_register;
        c.acc.ar.aarsize     = size;
        c.acc.ar.postexec    = postexec;
        c.acc.ar.transfer    = transfer;
        c.acc.ar.write       = write;
        c.acc.ar.regno       = regno;
        return c;
    endfunction

    // --------------------
    // stimulus table
    // --------------------
    function automatic void add_row(op_e op, logic [11:0] addr, logic [63:0] wdata,
                                    logic [7:0] be, logic [63:0] exp, cmderr_e err,
                                    logic [2:0] st);
        row_t r;
        r = '{op: op, addr: addr, wdata: wdata, be: be, exp: exp, err: err, st: st};
        stim.push_back(r);
    endfunction

    // status column is {cmdbusy, resuming, halted}
    function automatic void add_command(command_u c);
        logic [11:0] target;
        target = c.acc.ar.transfer ? abs_cmd_base : prog_buf_base;
        add_row(op_cmd, 12'h0, {32'b0, c}, 8'h0, 64'h0, cmderr_none, 3'b101);
        add_row(op_read, flags_base, 64'h0, 8'h0, 64'd1, cmderr_none, 3'b101);
        add_row(op_read, where_to_addr, 64'h0, 8'h0, jump_from_whereto(target),
                cmderr_none, 3'b101);
        for (int k = 0; k < 5; k++) begin
            add_row(op_read, abs_cmd_base + 12'(8 * k), 64'h0, 8'h0, exp_prog(c, k),
                    cmderr_none, 3'b101);
        end
        add_row(op_write, going_addr, 64'h0, 8'hFF, 64'h0, cmderr_none, 3'b101);
        add_row(op_write, halted_addr, 64'h0, 8'hFF, 64'h0, cmderr_none, 3'b001);
        add_row(op_wait, 12'h0, 64'h0, 8'h0, 64'h0, cmderr_none, 3'b001);
    endfunction

    function automatic void build_table();
        logic [31:0] rnd;
        logic [63:0] wr;
        logic [7:0]  be;
        rnd = $random(seed);
        // command before the halt and an unsupported command type
        add_row(op_cmd, 12'h0, {32'b0, make_cmd(1'b1, 1'b0, 1'b0, 3'd2, 16'h1008)}, 8'h0,
                64'h0, cmderr_halt_resume, 3'b000);
        add_row(op_cmd, 12'h0, {32'b0, quick_access, 24'h0}, 8'h0, 64'h0,
                cmderr_not_supported, 3'b000);
        add_row(op_write, halted_addr, 64'h0, 8'hFF, 64'h0, cmderr_none, 3'b001);
        add_command(make_cmd(1'b1, rnd[0], rnd[1], {2'b01, rnd[2]}, {11'h080, rnd[8:4]}));
        add_command(make_cmd(1'b1, rnd[9], rnd[10], {2'b01, rnd[11]}, {4'h0, rnd[27:16]}));
        add_command(make_cmd(1'b0, rnd[12], 1'b1, 3'd2, {11'h080, rnd[31:27]}));
        for (int i = 0; i < 4; i++) begin
            wr = {$random(seed), $random(seed)};
            be = $random(seed);
            add_row(op_write, data_addr, wr, be, merge_bytes(data_i, wr, be), cmderr_none,
                    3'b001);
        end
        add_row(op_read, data_addr, 64'h0, 8'h0, data_i, cmderr_none, 3'b001);
        for (int k = 0; k < 4; k++) begin
            add_row(op_read, prog_buf_base + 12'(8 * k), 64'h0, 8'h0,
                    {progbuf_i[2*k+1], progbuf_i[2*k]}, cmderr_none, 3'b001);
        end
        // resume handshake followed by an exception report
        add_row(op_resreq, 12'h0, 64'd1, 8'h0, 64'h0, cmderr_none, 3'b101);
        add_row(op_read, flags_base, 64'h0, 8'h0, 64'd2, cmderr_none, 3'b101);
        add_row(op_write, resuming_addr, 64'h0, 8'hFF, 64'h0, cmderr_none, 3'b110);
        add_row(op_read, where_to_addr, 64'h0, 8'h0, jump_from_whereto(resume_addr),
                cmderr_none, 3'b010);
        add_row(op_resreq, 12'h0, 64'd0, 8'h0, 64'h0, cmderr_none, 3'b000);
        add_row(op_write, exception_addr, 64'h0, 8'hFF, 64'h0, cmderr_exception, 3'b000);
    endfunction

    task automatic apply_row(row_t r);
        int   n;
        logic data_wr;
        data_wr = (r.op == op_write) && (r.addr == data_addr);
        if (r.op == op_wait) begin
            n = 0;
            while (cmdbusy_o && n < busy_limit) begin
                @(negedge clk_i);
                n++;
            end
            if (cmdbusy_o) begin
                $display("Timeout: cmdbusy_o still high after %0d cycles", busy_limit);
                fail_run();
            end
        end else begin
            @(posedge clk_i);
            case (r.op)
                op_cmd: begin
                    cmd_valid_i <= 1'b1;
                    cmd_i       <= r.wdata[31:0];
                end
                op_resreq: resumereq_i <= r.wdata[0];
                default: begin
                    req_i   <= 1'b1;
                    we_i    <= (r.op == op_write);
                    addr_i  <= 64'(r.addr);
                    wdata_i <= r.wdata;
                    be_i    <= r.be;
                end
            endcase
            @(negedge clk_i);
            check_err(cmderror_valid_o, cmderror_o, r.err);
            check_status({2'b00, data_valid_o}, {2'b00, data_wr}, "data_valid_o");
            if (data_wr) begin
                check_rdata(data_o, r.exp, "data_o");
            end
            @(posedge clk_i);
            req_i       <= 1'b0;
            we_i        <= 1'b0;
            cmd_valid_i <= 1'b0;
            @(negedge clk_i);
            if (r.op == op_read) check_rdata(rdata_o, r.exp, "rdata_o");
        end
        check_status({cmdbusy_o, resuming_o, halted_o}, r.st, "busy/resuming/halted");
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        haltreq_i   = 1'b0;
        resumereq_i = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        req_i       = 1'b0;
        we_i        = 1'b0;
        addr_i      = '0;
        wdata_i     = '0;
        be_i        = '0;
        seed        = 69;
        for (int i = 0; i < prog_buf_size; i++) progbuf_i[i] = $random(seed);
        for (int i = 0; i < data_count; i++) data_i[i] = $random(seed);
        build_table();
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        foreach (stim[i]) apply_row(stim[i]);
        if (UUT.i_props.assert_failed) begin
            $display("a bound assertion failed during the run");
            fail_run();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

/* all.f */
verilog/dbg_mem_pkg.sv
verilog/dbg_hart_ctrl.sv
verilog/dbg_abstract_prog.sv
verilog/dbg_bus_mem.sv
verilog/dbg_mem_top.sv
test/dbg_mem_properties.sv
test/tb_dbg_mem.sv
